//--- comboPkg.sv
package comboPkg;

    //////////////////////////////
    // Button inputs and codes
    //////////////////////////////

    // Width of the button vector
    localparam int numButtons = 6;

    // One code per button
    localparam int codeWidth = 3;

    // Code value doubles as bit index in the button vector
    localparam logic [codeWidth-1:0] btnUp     = 3'd0;
    localparam logic [codeWidth-1:0] btnDown   = 3'd1;
    localparam logic [codeWidth-1:0] btnLeft   = 3'd2;
    localparam logic [codeWidth-1:0] btnRight  = 3'd3;
    localparam logic [codeWidth-1:0] btnAttack = 3'd4;
    localparam logic [codeWidth-1:0] btnBlock  = 3'd5;

    // Step counter and length field, up to 12 entries
    localparam int stepWidth = 4;

    //////////////////////////////
    // Wishbone and register map
    //////////////////////////////

    // Word address and data widths
    localparam int wbAdrWidth  = 4;
    localparam int wbDataWidth = 32;

    // Word addresses
    localparam logic [wbAdrWidth-1:0] regCtrl    = 4'd0;
    localparam logic [wbAdrWidth-1:0] regStatus  = 4'd1;
    localparam logic [wbAdrWidth-1:0] regLength  = 4'd2;
    localparam logic [wbAdrWidth-1:0] regHits    = 4'd3;
    // Entry i at regSeqBase + i
    localparam logic [wbAdrWidth-1:0] regSeqBase = 4'd4;

    // Reset length, the Konami combo
    localparam logic [stepWidth-1:0] konamiLength = 4'd10;

endpackage

//--- buttonEdge.sv
`timescale 1ns/1ps

module buttonEdge (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic [comboPkg::numButtons-1:0] buttons,
    output logic                            pressValid,
    output logic [comboPkg::codeWidth-1:0]  pressCode,
    output logic                            pressMulti
);

    import comboPkg::*;

    // Two-flop synchronizer plus previous value
    logic [numButtons-1:0] syncFirst;
    logic [numButtons-1:0] syncSecond;
    logic [numButtons-1:0] syncPrev;

    // Rising edges on synchronized buttons
    logic [numButtons-1:0] rise;
    logic [codeWidth-1:0]  lowCode;
    logic                  multi;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            syncFirst  <= '0;
            syncSecond <= '0;
            syncPrev   <= '0;
        end else begin
            syncFirst  <= buttons;
            syncSecond <= syncFirst;
            syncPrev   <= syncSecond;
        end
    end

    assign rise = syncSecond & ~syncPrev;

    // Lowest index wins
    always_comb begin
        lowCode = '0;
        for (int i = numButtons - 1; i >= 0; i--) begin
            if (rise[i]) begin
                lowCode = codeWidth'(i);
            end
        end
    end

    // Two or more bits set, clearing the lowest leaves something
    assign multi = (rise & (rise - 1'b1)) != '0;

    // Registered press, one cycle wide
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pressValid <= 1'b0;
            pressCode  <= '0;
            pressMulti <= 1'b0;
        end else begin
            pressValid <= rise != '0;
            pressCode  <= lowCode;
            pressMulti <= multi;
        end
    end

endmodule

//--- comboWindow.sv
`timescale 1ns/1ps

module comboWindow #(
    parameter int windowCycles = 64
) (
    input  logic clk,
    input  logic rstN,
    input  logic restart,
    input  logic active,
    output logic expired
);

    // Wide enough to hold windowCycles itself
    localparam int cntWidth = $clog2(windowCycles + 1);

    logic [cntWidth-1:0] count;
    // Set by restart, dropped on expiry or when progress goes idle
    logic                armed;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            count   <= '0;
            armed   <= 1'b0;
            expired <= 1'b0;
        end else begin
            expired <= 1'b0;
            if (restart) begin
                count <= cntWidth'(windowCycles);
                armed <= 1'b1;
            end else if (!active) begin
                armed <= 1'b0;
            end else if (armed) begin
                // Last count, fire once and go idle
                if (count <= 1) begin
                    count   <= '0;
                    armed   <= 1'b0;
                    expired <= 1'b1;
                end else begin
                    count <= count - 1'b1;
                end
            end
        end
    end

endmodule

//--- comboSequencer.sv
`timescale 1ns/1ps

module comboSequencer #(
    parameter int maxSteps = 12
) (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           enable,
    input  logic                           pressValid,
    input  logic [comboPkg::codeWidth-1:0] pressCode,
    input  logic                           pressMulti,
    input  logic                           expired,
    output logic [comboPkg::stepWidth-1:0] seqAddr,
    input  logic [comboPkg::codeWidth-1:0] seqData,
    input  logic [comboPkg::stepWidth-1:0] seqLength,
    output logic [comboPkg::stepWidth-1:0] step,
    output logic                           windowRestart,
    output logic                           comboHit
);

    import comboPkg::*;

    //////////////////////////////
    // Match decode
    //////////////////////////////

    logic [stepWidth-1:0] stepNext;
    logic                 pressMatch;
    logic                 lastStep;
    logic                 evaluate;

    // Table lookup always follows progress
    assign seqAddr = step;

    assign stepNext = step + 1'b1;

    // Chords never match
    assign pressMatch = !pressMulti && (pressCode == seqData);

    // Also caught if length was shortened under us
    assign lastStep = (stepNext >= seqLength) || (stepNext >= maxSteps);

    // Presses only count with a non-empty sequence
    assign evaluate = pressValid && (seqLength != '0);

    //////////////////////////////
    // Step FSM
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            step          <= '0;
            windowRestart <= 1'b0;
            comboHit      <= 1'b0;
        end else begin
            // Pulses by default
            windowRestart <= 1'b0;
            comboHit      <= 1'b0;

            if (!enable || expired) begin
                // Disabled or too slow, drop progress
                step <= '0;
            end else if (evaluate) begin
                if (pressMatch) begin
                    if (lastStep) begin
                        // Whole combo done
                        step     <= '0;
                        comboHit <= 1'b1;
                    end else begin
                        step          <= stepNext;
                        windowRestart <= 1'b1;
                    end
                end else begin
                    // Mismatch restarts from the first entry
                    step <= '0;
                end
            end
        end
    end

endmodule

//--- comboRegs.sv
`timescale 1ns/1ps

module comboRegs #(
    parameter int maxSteps = 12
) (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             wbCyc,
    input  logic                             wbStb,
    input  logic                             wbWe,
    input  logic [comboPkg::wbAdrWidth-1:0]  wbAdr,
    input  logic [comboPkg::wbDataWidth-1:0] wbDatW,
    output logic [comboPkg::wbDataWidth-1:0] wbDatR,
    output logic                             wbAck,
    input  logic [comboPkg::stepWidth-1:0]   seqAddr,
    output logic [comboPkg::codeWidth-1:0]   seqData,
    output logic [comboPkg::stepWidth-1:0]   seqLength,
    output logic                             enable,
    output logic                             bypass,
    input  logic [comboPkg::stepWidth-1:0]   step,
    input  logic                             comboHit,
    output logic                             success
);

    import comboPkg::*;

    localparam int hitWidth = 16;

    logic [codeWidth-1:0]   seqTable [maxSteps];
    logic [hitWidth-1:0]    hits;

    // Bus decode
    logic                   access;
    logic                   writeCtrl;
    logic                   writeLength;
    logic                   writeHits;
    logic                   writeSeq;
    logic [wbAdrWidth-1:0]  seqIdx;
    logic                   seqMapped;
    logic [stepWidth-1:0]   lengthIn;
    logic [stepWidth-1:0]   lengthClamped;
    logic [wbDataWidth-1:0] readWord;

    // Reset contents of the table
    function automatic logic [codeWidth-1:0] konamiEntry(input int idx);
        case (idx)
            0, 1:    konamiEntry = btnUp;
            2, 3:    konamiEntry = btnDown;
            4, 6:    konamiEntry = btnLeft;
            5, 7:    konamiEntry = btnRight;
            8:       konamiEntry = btnAttack;
            9:       konamiEntry = btnBlock;
            default: konamiEntry = btnUp;
        endcase
    endfunction

    //////////////////////////////
    // Decode
    //////////////////////////////

    // New request, ack still low
    assign access = wbCyc && wbStb && !wbAck;

    assign seqIdx    = wbAdr - regSeqBase;
    assign seqMapped = (wbAdr >= regSeqBase) && (seqIdx < maxSteps);

    assign writeCtrl   = access && wbWe && (wbAdr == regCtrl);
    assign writeLength = access && wbWe && (wbAdr == regLength);
    assign writeHits   = access && wbWe && (wbAdr == regHits);
    assign writeSeq    = access && wbWe && seqMapped;

    // Length never beyond table size
    assign lengthIn      = wbDatW[stepWidth-1:0];
    assign lengthClamped = (lengthIn > maxSteps) ? stepWidth'(maxSteps) : lengthIn;

    // Sequencer lookup, out of range reads as code 0
    assign seqData = (seqAddr < maxSteps) ? seqTable[seqAddr] : '0;

    //////////////////////////////
    // Registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbAck     <= 1'b0;
            enable    <= 1'b1;
            bypass    <= 1'b0;
            success   <= 1'b0;
            seqLength <= konamiLength;
            hits      <= '0;
            for (int i = 0; i < maxSteps; i++) begin
                seqTable[i] <= konamiEntry(i);
            end
        end else begin
            wbAck <= access;

            // Set beats clear
            if (comboHit || bypass) begin
                success <= 1'b1;
            end else if (writeCtrl && wbDatW[2]) begin
                success <= 1'b0;
            end

            // Any write clears, otherwise count hits with wrap
            if (writeHits) begin
                hits <= '0;
            end else if (comboHit) begin
                hits <= hits + 1'b1;
            end

            if (writeCtrl) begin
                enable <= wbDatW[0];
                bypass <= wbDatW[1];
            end

            if (writeLength) begin
                seqLength <= lengthClamped;
            end

            if (writeSeq) begin
                seqTable[seqIdx] <= wbDatW[codeWidth-1:0];
            end
        end
    end

    //////////////////////////////
    // Read path
    //////////////////////////////

    always_comb begin
        readWord = '0;
        case (wbAdr)
            // Clear bit reads back as 0
            regCtrl:   readWord[1:0] = {bypass, enable};
            regStatus: begin
                readWord[0]   = success;
                readWord[7:4] = step;
            end
            regLength: readWord[stepWidth-1:0] = seqLength;
            regHits:   readWord[hitWidth-1:0] = hits;
            default: begin
                if (seqMapped) begin
                    readWord[codeWidth-1:0] = seqTable[seqIdx];
                end
            end
        endcase
    end

    // Captured with the ack edge
    always_ff @(posedge clk) begin
        if (access) begin
            wbDatR <= readWord;
        end
    end

endmodule

//--- comboTop.sv
`timescale 1ns/1ps

module comboTop #(
    parameter int windowCycles = 64,
    parameter int maxSteps     = 12
) (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             up,
    input  logic                             down,
    input  logic                             left,
    input  logic                             right,
    input  logic                             attack,
    input  logic                             block,
    input  logic                             wbCyc,
    input  logic                             wbStb,
    input  logic                             wbWe,
    input  logic [comboPkg::wbAdrWidth-1:0]  wbAdr,
    input  logic [comboPkg::wbDataWidth-1:0] wbDatW,
    output logic [comboPkg::wbDataWidth-1:0] wbDatR,
    output logic                             wbAck,
    output logic                             success
);

    import comboPkg::*;

    logic [numButtons-1:0] buttons;

    // Press path
    logic                  pressValid;
    logic [codeWidth-1:0]  pressCode;
    logic                  pressMulti;

    // Sequencer and timing window
    logic                  windowRestart;
    logic                  expired;
    logic                  active;
    logic [stepWidth-1:0]  step;
    logic                  comboHit;

    // Table lookup and control
    logic [stepWidth-1:0]  seqAddr;
    logic [codeWidth-1:0]  seqData;
    logic [stepWidth-1:0]  seqLength;
    logic                  enable;
    logic                  bypass;

    // Bit position equals button code
    assign buttons[btnUp]     = up;
    assign buttons[btnDown]   = down;
    assign buttons[btnLeft]   = left;
    assign buttons[btnRight]  = right;
    assign buttons[btnAttack] = attack;
    assign buttons[btnBlock]  = block;

    // Window only runs mid-combo
    assign active = step != '0;

    buttonEdge i_buttonEdge (
        .clk        (clk),
        .rstN       (rstN),
        .buttons    (buttons),
        .pressValid (pressValid),
        .pressCode  (pressCode),
        .pressMulti (pressMulti)
    );

    comboWindow #(
        .windowCycles (windowCycles)
    ) i_comboWindow (
        .clk     (clk),
        .rstN    (rstN),
        .restart (windowRestart),
        .active  (active),
        .expired (expired)
    );

    comboSequencer #(
        .maxSteps (maxSteps)
    ) i_comboSequencer (
        .clk           (clk),
        .rstN          (rstN),
        .enable        (enable),
        .pressValid    (pressValid),
        .pressCode     (pressCode),
        .pressMulti    (pressMulti),
        .expired       (expired),
        .seqAddr       (seqAddr),
        .seqData       (seqData),
        .seqLength     (seqLength),
        .step          (step),
        .windowRestart (windowRestart),
        .comboHit      (comboHit)
    );

    comboRegs #(
        .maxSteps (maxSteps)
    ) i_comboRegs (
        .clk       (clk),
        .rstN      (rstN),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .wbDatW    (wbDatW),
        .wbDatR    (wbDatR),
        .wbAck     (wbAck),
        .seqAddr   (seqAddr),
        .seqData   (seqData),
        .seqLength (seqLength),
        .enable    (enable),
        .bypass    (bypass),
        .step      (step),
        .comboHit  (comboHit),
        .success   (success)
    );

endmodule

//--- comboTb.sv
`timescale 1ns/1ps

module comboTb;

    import comboPkg::*;

    localparam int windowCycles = 64;
    // Ten entries leave word addresses 14 and 15 unmapped
    localparam int maxSteps     = 10;
    localparam int ackTimeout   = 20;
    localparam int pressCount   = 40;

    logic                   clk;
    logic                   rstN;
    logic                   up;
    logic                   down;
    logic                   left;
    logic                   right;
    logic                   attack;
    logic                   block;
    logic                   wbCyc;
    logic                   wbStb;
    logic                   wbWe;
    logic [wbAdrWidth-1:0]  wbAdr;
    logic [wbDataWidth-1:0] wbDatW;
    logic [wbDataWidth-1:0] wbDatR;
    logic                   wbAck;
    logic                   success;

    logic [31:0]            lfsrState = 32'h610a50f3;
    logic [codeWidth-1:0]   konami [10];

    // Reference model state
    logic [codeWidth-1:0]   modelTable [maxSteps];
    int unsigned            modelLength;
    int unsigned            modelStep;
    logic [15:0]            modelHits;
    logic                   modelSuccess;
    logic                   modelEnable;

    // success seen at the falling edge after each rising edge of a press
    logic                   successAt [1:6];

    comboTop #(
        .windowCycles (windowCycles),
        .maxSteps     (maxSteps)
    ) i_comboTop (
        .clk     (clk),
        .rstN    (rstN),
        .up      (up),
        .down    (down),
        .left    (left),
        .right   (right),
        .attack  (attack),
        .block   (block),
        .wbCyc   (wbCyc),
        .wbStb   (wbStb),
        .wbWe    (wbWe),
        .wbAdr   (wbAdr),
        .wbDatW  (wbDatW),
        .wbDatR  (wbDatR),
        .wbAck   (wbAck),
        .success (success)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    //////////////////////////////
    // Random numbers
    //////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic lfsrBit();
        logic feedback;
        feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], feedback};
        return feedback;
    endfunction

    function automatic int unsigned randBits(input int n);
        int unsigned value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | 32'(lfsrBit());
        end
        return value;
    endfunction

    //////////////////////////////
    // Checks and bus access
    //////////////////////////////

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic wbAccess(input logic we, input logic [wbAdrWidth-1:0] adr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        int waitCount;
        @(negedge clk);
        // Ack of the previous access lasts one cycle only
        checkValue("wbAck", 32'(wbAck), 32'd0);
        wbCyc     = 1'b1;
        wbStb     = 1'b1;
        wbWe      = we;
        wbAdr     = adr;
        wbDatW    = wdata;
        waitCount = 0;
        while (!wbAck && waitCount < ackTimeout) begin
            @(negedge clk);
            waitCount++;
        end
        if (!wbAck) begin
            $display("Timed out waiting for Wishbone ack at word 0x%h", adr);
            $display("ERRORS FOUND");
            $fatal(1);
        end else begin
            // Ack in the cycle after the request
            checkValue("wbAck latency", 32'(waitCount), 32'd1);
            rdata = wbDatR;
            // Drop the cycle before the next rising edge
            wbCyc = 1'b0;
            wbStb = 1'b0;
            wbWe  = 1'b0;
        end
    endtask

    task automatic wbWrite(input logic [wbAdrWidth-1:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        wbAccess(1'b1, adr, data, unused);
    endtask

    task automatic checkReg(input string name, input logic [wbAdrWidth-1:0] adr,
                            input logic [31:0] exp);
        logic [31:0] data;
        wbAccess(1'b0, adr, 32'd0, data);
        checkValue(name, data, exp);
    endtask

    task automatic waitSuccess(input logic level);
        int count;
        count = 0;
        while (success !== level && count < 10) begin
            @(negedge clk);
            count++;
        end
        if (success !== level) begin
            $display("Timed out waiting for success to reach %0d", level);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    //////////////////////////////
    // Buttons and model
    //////////////////////////////

    task automatic setButtons(input logic [numButtons-1:0] mask);
        // Bit index equals button code
        {block, attack, right, left, down, up} = mask;
    endtask

    // High for 3 rising edges then low for 3
    task automatic pressButtons(input logic [numButtons-1:0] mask);
        @(negedge clk);
        setButtons(mask);
        for (int k = 1; k <= 6; k++) begin
            @(negedge clk);
            successAt[k] = success;
            if (k == 3) begin
                setButtons('0);
            end
        end
    endtask

    task automatic modelPress(input logic [numButtons-1:0] mask);
        int bits;
        int code;
        bits = $countones(mask);
        code = 0;
        for (int i = numButtons - 1; i >= 0; i--) begin
            if (mask[i]) begin
                code = i;
            end
        end
        if (!modelEnable) begin
            modelStep = 0;
        end else if (modelLength != 0) begin
            // Single press of the expected code advances
            if (bits == 1 && code == int'(modelTable[modelStep])) begin
                if (modelStep + 1 >= modelLength) begin
                    modelStep    = 0;
                    modelHits    = modelHits + 16'd1;
                    modelSuccess = 1'b1;
                end else begin
                    modelStep = modelStep + 1;
                end
            end else begin
                modelStep = 0;
            end
        end
    endtask

    task automatic pressModel(input logic [numButtons-1:0] mask);
        pressButtons(mask);
        modelPress(mask);
    endtask

    task automatic pressCode(input int code);
        pressModel(numButtons'(1) << code);
    endtask

    task automatic checkModel();
        checkReg("status", regStatus, {24'd0, 4'(modelStep), 3'd0, modelSuccess});
        checkReg("hits", regHits, {16'd0, modelHits});
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    // Well inside the window
    task automatic shortGap();
        idle(8 + int'(randBits(4) % 13));
    endtask

    // Well past the window so progress is dropped
    task automatic longGap();
        idle(100 + int'(randBits(5)));
        modelStep = 0;
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        int          code;
        logic [31:0] lengthWord;

        rstN   = 1'b0;
        wbCyc  = 1'b0;
        wbStb  = 1'b0;
        wbWe   = 1'b0;
        wbAdr  = '0;
        wbDatW = '0;
        setButtons('0);

        konami = '{btnUp, btnUp, btnDown, btnDown, btnLeft,
                   btnRight, btnLeft, btnRight, btnAttack, btnBlock};
        for (int i = 0; i < maxSteps; i++) begin
            modelTable[i] = konami[i];
        end
        modelLength  = 10;
        modelStep    = 0;
        modelHits    = '0;
        modelSuccess = 1'b0;
        modelEnable  = 1'b1;

        repeat (2) @(negedge clk);
        rstN = 1'b1;

        // Reset values and Konami table
        checkReg("ctrl", regCtrl, 32'd1);
        checkReg("length", regLength, 32'd10);
        checkReg("hits", regHits, 32'd0);
        checkReg("status", regStatus, 32'd0);
        for (int i = 0; i < 10; i++) begin
            checkReg("seq entry", wbAdrWidth'(regSeqBase + i), 32'(konami[i]));
        end
        for (int a = regSeqBase + maxSteps; a < 16; a++) begin
            checkReg("unmapped word", wbAdrWidth'(a), 32'd0);
        end

        // Full Konami combo with short gaps
        for (int i = 0; i < 10; i++) begin
            pressCode(konami[i]);
            if (i < 9) begin
                shortGap();
            end
        end
        // Entry k holds success after sampling edge plus k-1
        checkValue("success after edge 3", 32'(successAt[4]), 32'd0);
        checkValue("success after edge 4", 32'(successAt[5]), 32'd1);
        checkModel();
        wbWrite(regCtrl, 32'h5);
        modelSuccess = 1'b0;
        checkValue("success", 32'(success), 32'd0);
        checkModel();

        // Partial combo then a gap that is too slow
        for (int i = 0; i < 4; i++) begin
            pressCode(konami[i]);
            shortGap();
        end
        checkModel();
        longGap();
        checkModel();
        for (int i = 4; i < 10; i++) begin
            pressCode(konami[i]);
            shortGap();
        end
        checkModel();

        // Chord mid-combo
        pressCode(btnUp);
        shortGap();
        pressCode(btnUp);
        checkModel();
        shortGap();
        pressModel((numButtons'(1) << btnDown) | (numButtons'(1) << btnLeft));
        checkModel();

        // Disabled
        wbWrite(regCtrl, 32'h0);
        modelEnable = 1'b0;
        pressCode(btnUp);
        checkModel();
        wbWrite(regCtrl, 32'h1);
        modelEnable = 1'b1;

        // Reprogram starting with a length past the table
        lengthWord = 32'(maxSteps + 1) + 32'(randBits(3) % (15 - maxSteps));
        wbWrite(regLength, lengthWord);
        checkReg("length", regLength, 32'(maxSteps));
        modelLength = 3 + randBits(2);
        wbWrite(regLength, 32'(modelLength));
        checkReg("length", regLength, 32'(modelLength));
        for (int i = 0; i < int'(modelLength); i++) begin
            modelTable[i] = codeWidth'(randBits(3) % 6);
            wbWrite(wbAdrWidth'(regSeqBase + i), 32'(modelTable[i]));
        end

        // Mostly matching presses with some random ones
        for (int n = 0; n < pressCount; n++) begin
            if (randBits(2) != 0) begin
                code = int'(modelTable[modelStep]);
            end else begin
                code = int'(randBits(3) % 6);
            end
            pressCode(code);
            checkModel();
            if (randBits(3) == 0) begin
                longGap();
            end else begin
                shortGap();
            end
        end

        // Bypass forces success
        wbWrite(regCtrl, 32'h5);
        checkValue("success", 32'(success), 32'd0);
        wbWrite(regCtrl, 32'h3);
        checkReg("ctrl", regCtrl, 32'h3);
        waitSuccess(1'b1);
        wbWrite(regCtrl, 32'h7);
        // Set wins on the very edge of the clear
        checkValue("success", 32'(success), 32'd1);
        idle(3);
        checkValue("success", 32'(success), 32'd1);
        wbWrite(regCtrl, 32'h1);
        wbWrite(regCtrl, 32'h5);
        checkValue("success", 32'(success), 32'd0);

        // Any write clears the hit counter
        checkReg("hits", regHits, {16'd0, modelHits});
        wbWrite(regHits, 32'h0000a5a5);
        modelHits = '0;
        checkReg("hits", regHits, 32'd0);

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- project.f
comboPkg.sv
buttonEdge.sv
comboWindow.sv
comboSequencer.sv
comboRegs.sv
comboTop.sv
comboTb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := comboTb
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := NO ERRORS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
